// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
SIM_ARGS  ?= +verilator+error+limit+1000
TOP       := ad9361_dual_rx_tb
FILELIST  := ad9361_dual_rx.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: ad9361_dual_rx.f
logic/ad9361_rx_pkg.sv
logic/rx_frame_demux.sv
logic/sample_packer.sv
logic/ad9361_dual_rx.sv
sim/ad9361_dual_rx_chk.sv
sim/ad9361_dual_rx_tb.sv

// File: logic/ad9361_dual_rx.sv
// dual AD9361 receive capture, two frame demultiplexers feeding one stream packer

module ad9361_dual_rx #(
  parameter bit reverse_lanes = 1'b0,
  parameter int burst_length  = 512
) (
  input  logic                                   m_axis_clk,
  input  logic                                   reset,
  input  logic [ad9361_rx_pkg::sample_width-1:0] rx_data_a,
  input  logic                                   rx_frame_a,
  input  logic [ad9361_rx_pkg::sample_width-1:0] rx_data_b,
  input  logic                                   rx_frame_b,
  input  logic                                   m_axis_tready,
  output logic                                   m_axis_tvalid,
  output logic                                   m_axis_tlast,
  output logic [ad9361_rx_pkg::tdata_width-1:0]  m_axis_tdata,
  output ad9361_rx_pkg::rx_status_t              status
);

  import ad9361_rx_pkg::*;

  chip_pair_t pair_a;
  chip_pair_t pair_b;
  logic       valid_a;
  logic       valid_b;

  // one demux per chip
  rx_frame_demux i_demux_a (
    .m_axis_clk  (m_axis_clk),
    .reset       (reset),
    .rx_data     (rx_data_a),
    .rx_frame    (rx_frame_a),
    .pair        (pair_a),
    .pair_valid  (valid_a),
    .align_error (status.align_error_a)
  );

  rx_frame_demux i_demux_b (
    .m_axis_clk  (m_axis_clk),
    .reset       (reset),
    .rx_data     (rx_data_b),
    .rx_frame    (rx_frame_b),
    .pair        (pair_b),
    .pair_valid  (valid_b),
    .align_error (status.align_error_b)
  );

  sample_packer #(
    .reverse_lanes (reverse_lanes),
    .burst_length  (burst_length)
  ) i_packer (
    .m_axis_clk    (m_axis_clk),
    .reset         (reset),
    .pair_a        (pair_a),
    .pair_b        (pair_b),
    .valid_a       (valid_a),
    .valid_b       (valid_b),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tdata  (m_axis_tdata),
    .overflow      (status.overflow)
  );

endmodule

// File: logic/ad9361_rx_pkg.sv
// shared widths and sample, channel-pair and status types for the dual AD9361 receive path

package ad9361_rx_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // raw ADC sample
  localparam int sample_width = 12;

  // one sample per lane in the stream word
  localparam int lane_width = 16;

  // full AXI-stream word, eight lanes
  localparam int tdata_width = 128;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  // one receive channel, I above Q
  typedef struct packed {
    logic [sample_width-1:0] i;
    logic [sample_width-1:0] q;
  } iq_sample_t;

  // both channels recovered from one chip frame
  typedef struct packed {
    iq_sample_t ch0;
    iq_sample_t ch1;
  } chip_pair_t;

  // sticky flags, cleared only by reset
  typedef struct packed {
    logic align_error_a;
    logic align_error_b;
    logic overflow;
  } rx_status_t;

endpackage

// File: logic/rx_frame_demux.sv
// recovers two I/Q channels from one chip's framed word bus and flags framing faults

module rx_frame_demux (
  input  logic                                  m_axis_clk,
  input  logic                                  reset,
  input  logic [ad9361_rx_pkg::sample_width-1:0] rx_data,
  input  logic                                  rx_frame,
  output ad9361_rx_pkg::chip_pair_t             pair,
  output logic                                  pair_valid,
  output logic                                  align_error
);

  import ad9361_rx_pkg::*;

  // registered input bus
  logic [sample_width-1:0] data_q;
  logic                    frame_q;
  logic                    frame_prev;

  // word position inside a frame
  logic                    active;
  logic [1:0]              phase;

  logic                    frame_start;
  logic                    level_ok;

  //////////////////////////////////////////////////
  // input sampling
  //////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    data_q <= rx_data;
  end

  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      frame_q    <= 1'b0;
      frame_prev <= 1'b0;
    end else begin
      frame_q    <= rx_frame;
      frame_prev <= frame_q;
    end
  end

  // I0 is the first high word after a low one
  assign frame_start = frame_q & ~frame_prev;

  // high on word 1, low on words 2 and 3
  assign level_ok = (frame_q == (phase == 2'd1));

  //////////////////////////////////////////////////
  // phase tracking and capture
  //////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      active      <= 1'b0;
      phase       <= 2'd0;
      pair_valid  <= 1'b0;
      align_error <= 1'b0;
    end else begin
      pair_valid <= 1'b0;
      if (!active) begin
        if (frame_start) begin
          active <= 1'b1;
          phase  <= 2'd1;
        end
      end else if (!level_ok) begin
        // partial frame is thrown away
        active      <= 1'b0;
        phase       <= 2'd0;
        align_error <= 1'b1;
      end else if (phase == 2'd3) begin
        active     <= 1'b0;
        phase      <= 2'd0;
        pair_valid <= 1'b1;
      end else begin
        phase <= phase + 2'd1;
      end
    end
  end

  // sample slots, written as each word goes by
  always_ff @(posedge m_axis_clk) begin
    if (!active && frame_start) begin
      pair.ch0.i <= data_q;
    end
    if (active) begin
      case (phase)
        2'd1:    pair.ch0.q <= data_q;
        2'd2:    pair.ch1.i <= data_q;
        2'd3:    pair.ch1.q <= data_q;
        default: pair.ch0.q <= pair.ch0.q;
      endcase
    end
  end

endmodule

// File: logic/sample_packer.sv
// packs both chips' channel pairs into one 128-bit AXI-stream word with burst framing

module sample_packer #(
  parameter bit reverse_lanes = 1'b0,
  parameter int burst_length  = 512
) (
  input  logic                                  m_axis_clk,
  input  logic                                  reset,
  input  ad9361_rx_pkg::chip_pair_t             pair_a,
  input  ad9361_rx_pkg::chip_pair_t             pair_b,
  input  logic                                  valid_a,
  input  logic                                  valid_b,
  input  logic                                  m_axis_tready,
  output logic                                  m_axis_tvalid,
  output logic                                  m_axis_tlast,
  output logic [ad9361_rx_pkg::tdata_width-1:0] m_axis_tdata,
  output logic                                  overflow
);

  import ad9361_rx_pkg::*;

  localparam int lane_count  = tdata_width / lane_width;
  localparam int count_width = $clog2(burst_length);

  // samples in lane order, index 7 is the top lane
  logic [sample_width-1:0] lane_sample [lane_count];
  logic [tdata_width-1:0]  packed_word;

  logic                    joint_valid;
  logic                    transfer;
  logic                    load;
  logic                    drop;

  logic [count_width-1:0]  burst_count;
  logic                    end_burst;

  //////////////////////////////////////////////////
  // lane mapping
  //////////////////////////////////////////////////

  assign lane_sample[7] = pair_a.ch0.i;
  assign lane_sample[6] = pair_a.ch0.q;
  assign lane_sample[5] = pair_a.ch1.i;
  assign lane_sample[4] = pair_a.ch1.q;
  assign lane_sample[3] = pair_b.ch0.i;
  assign lane_sample[2] = pair_b.ch0.q;
  assign lane_sample[1] = pair_b.ch1.i;
  assign lane_sample[0] = pair_b.ch1.q;

  for (genvar k = 0; k < lane_count; k++) begin : g_lane
    // mirrored order takes the sample from the opposite end
    localparam int src = reverse_lanes ? (lane_count - 1 - k) : k;

    assign packed_word[k*lane_width +: lane_width] =
      {{(lane_width - sample_width){1'b0}}, lane_sample[src]};
  end

  //////////////////////////////////////////////////
  // holding register and flow control
  //////////////////////////////////////////////////

  assign joint_valid = valid_a & valid_b;
  assign transfer    = m_axis_tvalid & m_axis_tready;

  // register is free when empty or emptying this cycle
  assign load = joint_valid & (~m_axis_tvalid | m_axis_tready);
  assign drop = joint_valid & m_axis_tvalid & ~m_axis_tready;

  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      m_axis_tvalid <= 1'b0;
    end else if (load) begin
      m_axis_tvalid <= 1'b1;
    end else if (transfer) begin
      m_axis_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge m_axis_clk) begin
    if (load) begin
      m_axis_tdata <= packed_word;
    end
  end

  // held word wins, the new one is lost
  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      overflow <= 1'b0;
    end else if (drop) begin
      overflow <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // burst counter
  //////////////////////////////////////////////////

  assign end_burst = (burst_count == count_width'(burst_length - 1));

  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      burst_count <= '0;
    end else if (transfer) begin
      if (end_burst) begin
        burst_count <= '0;
      end else begin
        burst_count <= burst_count + 1'b1;
      end
    end
  end

  assign m_axis_tlast = m_axis_tvalid & end_burst;

endmodule

// File: sim/ad9361_dual_rx_chk.sv
// stream stability, tlast and reset-state assertions for the dual receive top level

module ad9361_dual_rx_chk (
  input logic                                  m_axis_clk,
  input logic                                  reset,
  input logic                                  m_axis_tvalid,
  input logic                                  m_axis_tready,
  input logic                                  m_axis_tlast,
  input logic [ad9361_rx_pkg::tdata_width-1:0] m_axis_tdata
);

  // running count of assertion failures
  int unsigned fail_count = 0;

  // holding register empty right after reset
  assert property (@(posedge m_axis_clk) reset |=> !m_axis_tvalid)
    else begin
      $error("tvalid high in the cycle after reset");
      fail_count++;
    end

  // a stalled word stays put until it is taken
  assert property (@(posedge m_axis_clk) disable iff (reset)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else begin
      $error("stream word changed while stalled");
      fail_count++;
    end

  assert property (@(posedge m_axis_clk) disable iff (reset) m_axis_tlast |-> m_axis_tvalid)
    else begin
      $error("tlast high without tvalid");
      fail_count++;
    end

endmodule

// File: sim/ad9361_dual_rx_tb.sv
// testbench for the dual AD9361 receive path with file-driven frames and a checked stream consumer

module ad9361_dual_rx_tb;

  import ad9361_rx_pkg::*;

  localparam int burst_len  = 4;
  localparam int row_words  = 11;
  localparam int max_rows   = 32;
  localparam int wait_limit = 2000;

  // one expected stream word in both lane orders
  typedef struct packed {
    logic [tdata_width-1:0] word;
    logic [tdata_width-1:0] word_rev;
    logic                   stall;
  } expect_t;

  logic                    m_axis_clk;
  logic                    reset;
  logic [sample_width-1:0] rx_data_a;
  logic                    rx_frame_a;
  logic [sample_width-1:0] rx_data_b;
  logic                    rx_frame_b;
  logic                    m_axis_tready;
  logic                    m_axis_tvalid;
  logic                    m_axis_tlast;
  logic [tdata_width-1:0]  m_axis_tdata;
  rx_status_t              status;
  logic                    rev_tvalid;
  logic                    rev_tlast;
  logic [tdata_width-1:0]  rev_tdata;
  rx_status_t              rev_status;

  // eight samples, stall, drop and chip A fault per row
  logic [sample_width-1:0] test_mem [row_words*max_rows];
  expect_t                 expect_q [$];
  int                      errors;
  int                      row_count;
  int                      xfer_count;
  int                      hold_left;
  int                      seed;
  logic                    ovf_expected;
  logic                    fault_seen;

  ad9361_dual_rx #(.reverse_lanes(1'b0), .burst_length(burst_len)) i_ad9361_dual_rx (
    .m_axis_clk (m_axis_clk), .reset (reset),
    .rx_data_a (rx_data_a), .rx_frame_a (rx_frame_a),
    .rx_data_b (rx_data_b), .rx_frame_b (rx_frame_b),
    .m_axis_tready (m_axis_tready), .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast (m_axis_tlast), .m_axis_tdata (m_axis_tdata), .status (status)
  );

  // second instance with mirrored lanes on the same frames and tready
  ad9361_dual_rx #(.reverse_lanes(1'b1), .burst_length(burst_len)) i_ad9361_dual_rx_rev (
    .m_axis_clk (m_axis_clk), .reset (reset),
    .rx_data_a (rx_data_a), .rx_frame_a (rx_frame_a),
    .rx_data_b (rx_data_b), .rx_frame_b (rx_frame_b),
    .m_axis_tready (m_axis_tready), .m_axis_tvalid (rev_tvalid),
    .m_axis_tlast (rev_tlast), .m_axis_tdata (rev_tdata), .status (rev_status)
  );

  bind ad9361_dual_rx ad9361_dual_rx_chk i_chk (
    .m_axis_clk (m_axis_clk), .reset (reset), .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready), .m_axis_tlast (m_axis_tlast),
    .m_axis_tdata (m_axis_tdata)
  );

  initial begin
    m_axis_clk = 1'b0;
    forever #50 m_axis_clk = ~m_axis_clk;
  end

  //////////////////////////////////////////////////
  // expected words and checking
  //////////////////////////////////////////////////

  // sample n goes to lane 7-n, or lane n when mirrored
  function automatic logic [tdata_width-1:0] pack_lanes(input int row, input bit mirror);
    logic [tdata_width-1:0] w;
    int                     lane;
    w = '0;
    for (int n = 0; n < 8; n++) begin
      lane = mirror ? n : 7 - n;
      w[lane*lane_width +: sample_width] = test_mem[row*row_words + n];
    end
    return w;
  endfunction

  // long forced stall or a short random one
  function automatic int pick_hold(input logic stall);
    logic [31:0] draw;
    if (stall) begin
      return 8;
    end
    draw = $random(seed);
    return int'(draw[1:0]);
  endfunction

  task automatic check_value(input string name, input logic [tdata_width-1:0] got,
                             input logic [tdata_width-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic load_expected();
    expect_t e;
    int      base;
    row_count = 0;
    // a row read from the file has a stall flag of 0 or 1
    while (row_count < max_rows && test_mem[row_count*row_words + 8] < 12'd2) begin
      row_count++;
    end
    for (int r = 0; r < row_count; r++) begin
      base = r * row_words;
      if (test_mem[base+10] != '0) begin
        fault_seen = 1'b1;
      end else if (test_mem[base+9] == '0) begin
        e.word     = pack_lanes(r, 1'b0);
        e.word_rev = pack_lanes(r, 1'b1);
        e.stall    = test_mem[base+8][0];
        expect_q.push_back(e);
      end
    end
    if (expect_q.size() == 0) begin
      errors++;
      $display("No usable frames were read from the test file");
    end else begin
      hold_left = pick_hold(expect_q[0].stall);
    end
  endtask

  task automatic accept_word();
    expect_t e;
    if (expect_q.size() == 0) begin
      errors++;
      $display("Unexpected stream word %h after all expected words", m_axis_tdata);
    end else begin
      e = expect_q.pop_front();
      if (e.stall) begin
        ovf_expected = 1'b1;
      end
      if (xfer_count == 0) begin
        check_value("status.align_error_a", status.align_error_a, 1'b0);
      end
      check_value("m_axis_tdata", m_axis_tdata, e.word);
      check_value("rev m_axis_tdata", rev_tdata, e.word_rev);
      check_value("rev m_axis_tvalid", rev_tvalid, 1'b1);
      check_value("m_axis_tlast", m_axis_tlast, (xfer_count % burst_len) == burst_len - 1);
      check_value("rev m_axis_tlast", rev_tlast, (xfer_count % burst_len) == burst_len - 1);
      check_value("status.overflow", status.overflow, ovf_expected);
      check_value("rev status.overflow", rev_status.overflow, ovf_expected);
      if (expect_q.size() != 0) begin
        hold_left = pick_hold(expect_q[0].stall);
      end
    end
    xfer_count++;
  endtask

  // tready stays low while the head word's hold counts down
  always @(posedge m_axis_clk) begin
    if (!reset) begin
      if (m_axis_tvalid && m_axis_tready) begin
        accept_word();
      end else if (m_axis_tvalid && hold_left > 0) begin
        hold_left--;
      end
      m_axis_tready <= (hold_left == 0);
    end
  end

  //////////////////////////////////////////////////
  // frame driver and run control
  //////////////////////////////////////////////////

  task automatic drive_frame(input int row);
    int         base;
    logic [3:0] level_a;
    base    = row * row_words;
    // bit w is the rx_frame level of word w
    level_a = (test_mem[base+10] != '0) ? 4'b0111 : 4'b0011;
    for (int w = 0; w < 4; w++) begin
      @(posedge m_axis_clk);
      rx_data_a  <= test_mem[base+w];
      rx_frame_a <= level_a[w];
      rx_data_b  <= test_mem[base+4+w];
      rx_frame_b <= (w < 2);
    end
  endtask

  task automatic wait_for_words();
    int cycles;
    cycles = 0;
    while (expect_q.size() != 0 && cycles < wait_limit) begin
      @(negedge m_axis_clk);
      cycles++;
    end
    if (expect_q.size() != 0) begin
      errors++;
      $display("Timeout: %0d expected words never left the stream", expect_q.size());
    end
  endtask

  initial begin
    reset         = 1'b1;
    rx_data_a     = '0;
    rx_frame_a    = 1'b0;
    rx_data_b     = '0;
    rx_frame_b    = 1'b0;
    m_axis_tready = 1'b0;
    errors        = 0;
    xfer_count    = 0;
    hold_left     = 0;
    ovf_expected  = 1'b0;
    fault_seen    = 1'b0;
    seed          = 32'hb662c3d1;
    // rows missing from the file keep all ones
    for (int i = 0; i < row_words * max_rows; i++) begin
      test_mem[i] = '1;
    end
    $readmemh("sim/ad9361_dual_rx_tests.txt", test_mem);
    load_expected();
    repeat (5) @(posedge m_axis_clk);
    reset <= 1'b0;
    for (int r = 0; r < row_count; r++) begin
      drive_frame(r);
    end
    @(posedge m_axis_clk);
    rx_data_a  <= '0;
    rx_frame_a <= 1'b0;
    rx_data_b  <= '0;
    rx_frame_b <= 1'b0;
    wait_for_words();
    // a few idle cycles to catch stray words
    repeat (20) @(negedge m_axis_clk);
    check_value("status.align_error_a", status.align_error_a, fault_seen);
    check_value("status.align_error_b", status.align_error_b, 1'b0);
    check_value("rev status.align_error_a", rev_status.align_error_a, fault_seen);
    check_value("rev status.align_error_b", rev_status.align_error_b, 1'b0);
    errors += i_ad9361_dual_rx.i_chk.fail_count + i_ad9361_dual_rx_rev.i_chk.fail_count;
    $display("Done: %0d words transferred, %0d errors", xfer_count, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: sim/ad9361_dual_rx_tests.txt
// columns: chip A I0 Q0 I1 Q1, chip B I0 Q0 I1 Q1, stall, drop, chip A fault
// stall holds tready low 8 cycles, the next two frames are then dropped
001 002 003 004 005 006 007 008 0 0 0
fff 800 7ff 123 abc def 456 789 0 0 0
111 222 333 444 555 666 777 888 0 0 0
0a1 0a2 0a3 0a4 0b1 0b2 0b3 0b4 1 0 0
5a5 a5a 5a5 a5a 3c3 c3c 3c3 c3c 0 1 0
100 200 300 400 500 600 700 800 0 1 0
9ab 8bc 7cd 6de 5ef 4f0 301 212 0 0 0
e01 e02 e03 e04 d01 d02 d03 d04 0 0 1
321 432 543 654 765 876 987 a98 0 0 0
0f0 f0f 0f0 f0f 00f ff0 0ff f00 0 0 0
135 246 357 468 579 68a 79b 8ac 0 0 0
c01 c02 c03 c04 c05 c06 c07 c08 1 0 0
777 666 555 444 333 222 111 000 0 1 0
0de 0ad 0be 0ef 0ca 0fe 0ba 0be 0 1 0
246 8ac e02 468 ace 024 68a ce0 0 0 0
3ff 400 1ff 200 0ff 300 07f 380 0 0 0
010 020 030 040 050 060 070 080 0 0 0
8e1 8e2 8e3 8e4 8e5 8e6 8e7 8e8 0 0 0
fff fff fff fff fff fff fff fff 0 0 0
000 000 000 000 000 000 000 000 0 0 0
